/* tb.f */
mips_pkg.sv
maindec.sv
aludec.sv
branchdec.sv
load_align.sv
decode_stage.sv
tb_decode.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_decode -o Vtb_decode
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_decode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi

echo "Testbench reported no failure"
exit 0

/* tb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode import mips_pkg::*; ();

  localparam logic [5:0] LEGAL_OPS [25] = '{
    OP_RTYPE, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
    OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
    OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_SB, OP_SH, OP_SW
  };
  localparam logic [5:0] LEGAL_FN [14] = '{
    FN_JR, FN_JALR, FN_MTHI, FN_MTLO, FN_ADDU, FN_SUBU, FN_AND,
    FN_OR, FN_XOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA
  };
  localparam logic [4:0]  LEGAL_RT [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
  localparam logic [5:0]  LOAD_OPS [8] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
                                           OP_LWL, OP_LWR, OP_ADDIU};
  localparam logic [20:0] RESET_VEC = {11'd0, ALU_ADD, BR_NONE, LD_NONE};

  logic        clk, rst, instr_valid;
  logic [31:0] instr, mem_rdata, rt_value;
  logic [1:0]  addr_low;
  logic        ctrl_valid, regwrite, regdst2, regdst1, alusrc, branch;
  logic        mem_write, memtoreg, jump1, jump, illegal, link;
  logic [3:0]  alu_ctrl;
  logic [2:0]  branch_cond, load_code;
  logic [31:0] load_data;
  logic [20:0] act_vec;    // All registered controls in expected layout
  logic [31:0] rng;        // LCG state
  logic [20:0] exp_q [$];  // Expected controls in issue order
  string       name_q [$];
  logic [20:0] held;       // Last controls seen with ctrl_valid
  logic        prev_valid; // instr_valid at the previous edge
  int          errors, checks;

  decode_stage u_dut (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
    .mem_rdata(mem_rdata), .addr_low(addr_low), .rt_value(rt_value),
    .ctrl_valid(ctrl_valid), .regwrite(regwrite), .regdst2(regdst2), .regdst1(regdst1),
    .alusrc(alusrc), .branch(branch), .mem_write(mem_write), .memtoreg(memtoreg),
    .jump1(jump1), .jump(jump), .illegal(illegal), .link(link), .alu_ctrl(alu_ctrl),
    .branch_cond(branch_cond), .load_code(load_code), .load_data(load_data)
  );

  assign act_vec = {regwrite, regdst2, regdst1, alusrc, branch, mem_write, memtoreg,
                    jump1, jump, illegal, link, alu_ctrl, branch_cond, load_code};

  always #10 clk = ~clk; // 20 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Flags rw rd2 rd1 src br mw m2r j1 j ill followed by aluop class and load code
  function automatic logic [14:0] exp_controls(input logic [5:0] op, input logic [5:0] funct,
                                               input logic [4:0] rt);
    logic [9:0] f;
    logic [1:0] a;
    logic [2:0] ld;
    f  = 10'b0000000001; // Illegal until matched
    a  = AOP_ADD;
    ld = LD_NONE;
    if (op == OP_RTYPE) begin
      if (funct == FN_JR) begin
        f = 10'b0000100110;
        a = AOP_PASS;
      end else if (funct == FN_JALR) begin
        f = 10'b1100100110;
        a = AOP_PASS;
      end else if (funct inside {FN_MTHI, FN_MTLO}) begin
        f = 10'b0000000000;
        a = AOP_DECODE;
      end else if (funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                                 FN_SLL, FN_SRL, FN_SRA}) begin
        f = 10'b1010000000;
        a = AOP_DECODE;
      end
    end else if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR}) begin
      f = 10'b1001001000;
      case (op)
        OP_LB:   ld = LD_B;
        OP_LBU:  ld = LD_BU;
        OP_LH:   ld = LD_H;
        OP_LHU:  ld = LD_HU;
        OP_LWL:  ld = LD_WL;
        OP_LWR:  ld = LD_WR;
        default: ld = LD_W;
      endcase
    end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
      f = 10'b0001010000;
    end else if (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ}) begin
      f = 10'b0000100000;
      a = AOP_DECODE;
    end else if (op == OP_REGIMM && rt inside {RT_BLTZ, RT_BGEZ}) begin
      f = 10'b0000100000;
      a = AOP_DECODE;
    end else if (op == OP_REGIMM && rt inside {RT_BLTZAL, RT_BGEZAL}) begin
      f = 10'b1100100000; // Links into $31
      a = AOP_DECODE;
    end else if (op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
      f = 10'b1001000000;
      a = AOP_DECODE;
    end else if (op == OP_J) begin
      f = 10'b0000100010;
      a = AOP_PASS;
    end else if (op == OP_JAL) begin
      f = 10'b1100100010;
      a = AOP_PASS;
    end
    return {f, a, ld};
  endfunction

  function automatic logic [3:0] exp_alu(input logic [1:0] aop, input logic [5:0] op,
                                         input logic [5:0] funct);
    if (aop == AOP_PASS) return ALU_PASSA;
    if (aop != AOP_DECODE) return ALU_ADD;
    if (op == OP_RTYPE) begin
      case (funct)
        FN_SUBU: return ALU_SUB;
        FN_AND:  return ALU_AND;
        FN_OR:   return ALU_OR;
        FN_XOR:  return ALU_XOR;
        FN_SLT:  return ALU_SLT;
        FN_SLTU: return ALU_SLTU;
        FN_SLL:  return ALU_SLL;
        FN_SRL:  return ALU_SRL;
        FN_SRA:  return ALU_SRA;
        FN_MTHI: return ALU_MTHI;
        FN_MTLO: return ALU_MTLO;
        default: return ALU_ADD; // ADDU and the rest
      endcase
    end
    if (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM}) return ALU_SUB;
    case (op)
      OP_ANDI:  return ALU_AND;
      OP_ORI:   return ALU_OR;
      OP_XORI:  return ALU_XOR;
      OP_SLTI:  return ALU_SLT;
      OP_SLTIU: return ALU_SLTU;
      OP_LUI:   return ALU_LUI;
      default:  return ALU_ADD;
    endcase
  endfunction

  // Condition code then link bit
  function automatic logic [3:0] exp_branch(input logic [5:0] op, input logic [4:0] rt);
    if (op == OP_BEQ) return {BR_EQ, 1'b0};
    if (op == OP_BNE) return {BR_NE, 1'b0};
    if (op == OP_BLEZ) return {BR_LEZ, 1'b0};
    if (op == OP_BGTZ) return {BR_GTZ, 1'b0};
    if (op == OP_REGIMM) begin
      if (rt == RT_BLTZ || rt == RT_BLTZAL) return {BR_LTZ, rt[4]};
      if (rt == RT_BGEZ || rt == RT_BGEZAL) return {BR_GEZ, rt[4]};
    end
    return {BR_NONE, 1'b0};
  endfunction

  function automatic logic [20:0] exp_all(input instr_t w);
    logic [14:0] c;
    logic [3:0]  b;
    c = exp_controls(w.r.op, w.r.funct, w.i.rt);
    b = exp_branch(w.i.op, w.i.rt);
    return {c[14:5], b[0], exp_alu(c[4:3], w.r.op, w.r.funct), b[3:1], c[2:0]};
  endfunction

  function automatic logic [31:0] exp_load(input logic [2:0] code, input logic [1:0] off,
                                           input logic [31:0] mem, input logic [31:0] rtv);
    logic [7:0]  mb [4];
    logic [7:0]  ob [4];
    logic [15:0] h;
    for (int k = 0; k < 4; k++) begin
      mb[k] = mem[31-8*k -: 8]; // Byte 0 is most significant
      ob[k] = rtv[31-8*k -: 8];
    end
    h = {mb[{off[1], 1'b0}], mb[{off[1], 1'b1}]};
    case (code)
      LD_B:  return {{24{mb[off][7]}}, mb[off]};
      LD_BU: return {24'd0, mb[off]};
      LD_H:  return {{16{h[15]}}, h};
      LD_HU: return {16'd0, h};
      LD_WL: begin
        for (int k = 0; k < 4; k++) if (k >= off) ob[k-off] = mb[k];
        return {ob[0], ob[1], ob[2], ob[3]};
      end
      LD_WR: begin
        for (int k = 0; k < 4; k++) if (k <= off) ob[3-off+k] = mb[k];
        return {ob[0], ob[1], ob[2], ob[3]};
      end
      default: return mem; // Word and no-load
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("checks=%0d errors=%0d", checks, errors);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic next_rand(output logic [31:0] v);
    rng = lcg_next(rng);
    v   = rng;
  endtask

  task automatic send(input instr_t w);
    @(negedge clk);
    instr       = w;
    instr_valid = 1'b1;
  endtask

  task automatic idle();
    logic [31:0] r;
    @(negedge clk);
    next_rand(r);
    instr       = r; // Junk while invalid
    instr_valid = 1'b0;
  endtask

  task automatic make_legal(output instr_t w);
    logic [31:0] r;
    next_rand(r);
    w = r;
    next_rand(r);
    w.r.op = LEGAL_OPS[r[31:16] % 25];
    if (w.r.op == OP_RTYPE) w.r.funct = LEGAL_FN[r[15:8] % 14];
    if (w.r.op == OP_REGIMM) w.i.rt = LEGAL_RT[r[7:6]];
  endtask

  task automatic wait_ctrl_valid(input int limit);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(posedge clk);
      if (ctrl_valid) seen = 1'b1;
    end
    if (!seen) abort_run("Timeout, ctrl_valid never rose after an instruction was sent");
  endtask

  task automatic wait_drain(input int limit);
    logic done;
    done = 1'b0;
    for (int n = 0; n < limit && !done; n++) begin
      @(negedge clk);
      if (exp_q.size() == 0) done = 1'b1;
    end
    if (!done) abort_run("Timeout, issued instructions never came out of the decode stage");
  endtask

  // Pre-edge values are the result of the previous capture
  always @(posedge clk) begin : compare_proc
    logic [20:0] exp_v;
    if (rst) begin
      exp_q.delete();
      name_q.delete();
      held       = RESET_VEC;
      prev_valid = 1'b0;
    end else begin
      check("ctrl_valid", {31'd0, prev_valid}, {31'd0, ctrl_valid});
      if (ctrl_valid && exp_q.size() != 0) begin
        exp_v = exp_q.pop_front();
        check(name_q.pop_front(), {11'd0, exp_v}, {11'd0, act_vec});
        held = exp_v;
      end else if (!ctrl_valid) begin
        check("hold", {11'd0, held}, {11'd0, act_vec}); // Also the reset values
      end
      if (instr_valid) begin
        exp_q.push_back(exp_all(instr));
        name_q.push_back($sformatf("ctrl instr=%h", instr));
      end
      prev_valid = instr_valid;
    end
  end

  initial begin
    instr_t      w;
    logic [31:0] r, md, rv;
    logic [20:0] exp_w;
    logic [2:0]  code;
    clk = 1'b0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = 32'd0;
    mem_rdata = 32'd0;
    addr_low = 2'd0;
    rt_value = 32'd0;
    rng = 32'd77;
    errors = 0;
    checks = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    repeat (4) idle(); // Reset values must hold

    for (int op = 0; op < 64; op++) begin // Every opcode, legal or not
      next_rand(r);
      w = r;
      w.r.op = op[5:0];
      send(w);
    end
    for (int fn = 0; fn < 64; fn++) begin // Every function code
      next_rand(r);
      w = r;
      w.r.op = OP_RTYPE;
      w.r.funct = fn[5:0];
      send(w);
      if (fn % 9 == 0) idle();
    end
    for (int rt = 0; rt < 32; rt++) begin // Every REGIMM selector
      next_rand(r);
      w = r;
      w.i.op = OP_REGIMM;
      w.i.rt = rt[4:0];
      send(w);
    end
    for (int n = 0; n < 300; n++) begin
      next_rand(r);
      if (r[31:29] == 3'd0) idle();
      if (r[28:27] == 2'd0) begin
        next_rand(r);
        w = r; // Raw word
      end else begin
        make_legal(w);
      end
      send(w);
    end
    idle();
    wait_drain(20);

    for (int i = 0; i < 8; i++) begin // Each load code plus a non-load
      next_rand(r);
      w = r;
      w.i.op = LOAD_OPS[i];
      send(w);
      idle();
      wait_ctrl_valid(10);
      exp_w = exp_all(w);
      code  = exp_w[2:0];
      for (int off = 0; off < 4; off++) begin
        for (int n = 0; n < 4; n++) begin
          next_rand(md);
          next_rand(rv);
          @(negedge clk);
          addr_low  = off[1:0];
          mem_rdata = md;
          rt_value  = rv;
          @(posedge clk); // load_code held and inputs settled since negedge
          check($sformatf("load code=%0d off=%0d", code, off),
                exp_load(code, off[1:0], md, rv), load_data);
        end
      end
    end

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] mem_rdata,
  input  logic [1:0]  addr_low,
  input  logic [31:0] rt_value,
  output logic        ctrl_valid,
  output logic        regwrite,
  output logic        regdst2,
  output logic        regdst1,
  output logic        alusrc,
  output logic        branch,
  output logic        mem_write,
  output logic        memtoreg,
  output logic        jump1,
  output logic        jump,
  output logic        illegal,
  output logic        link,
  output logic [3:0]  alu_ctrl,
  output logic [2:0]  branch_cond,
  output logic [2:0]  load_code,
  output logic [31:0] load_data
);

  instr_t     iw;
  logic       regwrite_d, regdst2_d, regdst1_d, alusrc_d, branch_d;
  logic       mem_write_d, memtoreg_d, jump1_d, jump_d, illegal_d, link_d;
  logic [1:0] aluop_d;     // Class from main decoder to ALU decoder
  logic [3:0] alu_ctrl_d;
  logic [2:0] branch_cond_d;
  logic [2:0] load_code_d;

  assign iw = instr;

  maindec u_maindec (
    .op(iw.r.op), .funct(iw.r.funct), .rt(iw.i.rt),
    .regwrite(regwrite_d), .regdst2(regdst2_d), .regdst1(regdst1_d),
    .alusrc(alusrc_d), .branch(branch_d), .mem_write(mem_write_d),
    .memtoreg(memtoreg_d), .jump1(jump1_d), .jump(jump_d),
    .illegal(illegal_d), .aluop(aluop_d), .load_code(load_code_d)
  );

  aludec u_aludec (
    .aluop(aluop_d), .op(iw.r.op), .funct(iw.r.funct), .alu_ctrl(alu_ctrl_d)
  );

  branchdec u_branchdec (
    .op(iw.i.op), .rt(iw.i.rt), .branch_cond(branch_cond_d), .link(link_d)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_valid  <= 1'b0;
      regwrite    <= 1'b0;
      regdst2     <= 1'b0;
      regdst1     <= 1'b0;
      alusrc      <= 1'b0;
      branch      <= 1'b0;
      mem_write   <= 1'b0;
      memtoreg    <= 1'b0;
      jump1       <= 1'b0;
      jump        <= 1'b0;
      illegal     <= 1'b0;
      link        <= 1'b0;
      alu_ctrl    <= ALU_ADD;
      branch_cond <= BR_NONE;
      load_code   <= LD_NONE;
    end else begin
      ctrl_valid <= instr_valid; // One cycle behind the strobe
      if (instr_valid) begin     // Hold last controls otherwise
        regwrite    <= regwrite_d;
        regdst2     <= regdst2_d;
        regdst1     <= regdst1_d;
        alusrc      <= alusrc_d;
        branch      <= branch_d;
        mem_write   <= mem_write_d;
        memtoreg    <= memtoreg_d;
        jump1       <= jump1_d;
        jump        <= jump_d;
        illegal     <= illegal_d;
        link        <= link_d;
        alu_ctrl    <= alu_ctrl_d;
        branch_cond <= branch_cond_d;
        load_code   <= load_code_d;
      end
    end
  end

  // Write-back formatting uses the registered load code
  load_align u_load_align (
    .load_code(load_code), .addr_low(addr_low), .mem_rdata(mem_rdata),
    .rt_value(rt_value), .load_data(load_data)
  );

endmodule

`default_nettype wire

/* load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align import mips_pkg::*; (
  input  logic [2:0]  load_code,
  input  logic [1:0]  addr_low,
  input  logic [31:0] mem_rdata,
  input  logic [31:0] rt_value,
  output logic [31:0] load_data
);

  logic [7:0]  byte_sel; // Addressed byte lane
  logic [15:0] half_sel; // Addressed halfword
  logic [31:0] lwl_data;
  logic [31:0] lwr_data;

  // Big-endian lanes, byte 0 sits in bits 31:24
  always_comb begin
    case (addr_low)
      2'd0:    byte_sel = mem_rdata[31:24];
      2'd1:    byte_sel = mem_rdata[23:16];
      2'd2:    byte_sel = mem_rdata[15:8];
      default: byte_sel = mem_rdata[7:0];
    endcase
  end

  assign half_sel = addr_low[1] ? mem_rdata[15:0] : mem_rdata[31:16]; // Offset 0 is upper half

  // LWL, bytes from offset to word end land in the high end of rt
  always_comb begin
    case (addr_low)
      2'd0:    lwl_data = mem_rdata;
      2'd1:    lwl_data = {mem_rdata[23:0], rt_value[7:0]};
      2'd2:    lwl_data = {mem_rdata[15:0], rt_value[15:0]};
      default: lwl_data = {mem_rdata[7:0], rt_value[23:0]};
    endcase
  end

  // LWR, bytes from word start to offset land in the low end of rt
  always_comb begin
    case (addr_low)
      2'd0:    lwr_data = {rt_value[31:8], mem_rdata[31:24]};
      2'd1:    lwr_data = {rt_value[31:16], mem_rdata[31:16]};
      2'd2:    lwr_data = {rt_value[31:24], mem_rdata[31:8]};
      default: lwr_data = mem_rdata;
    endcase
  end

  always_comb begin
    case (load_code)
      LD_B:    load_data = {{24{byte_sel[7]}}, byte_sel};  // Sign extend
      LD_BU:   load_data = {24'd0, byte_sel};
      LD_H:    load_data = {{16{half_sel[15]}}, half_sel}; // Sign extend
      LD_HU:   load_data = {16'd0, half_sel};
      LD_W:    load_data = mem_rdata;
      LD_WL:   load_data = lwl_data;
      LD_WR:   load_data = lwr_data;
      default: load_data = mem_rdata; // LD_NONE
    endcase
  end

endmodule

`default_nettype wire

/* branchdec.sv */
`timescale 1ns/1ps
`default_nettype none

module branchdec import mips_pkg::*; (
  input  logic [5:0] op,
  input  logic [4:0] rt,
  output logic [2:0] branch_cond,
  output logic       link
);

  always_comb begin
    branch_cond = BR_NONE;
    link        = 1'b0;
    case (op)
      OP_BEQ:  branch_cond = BR_EQ;
      OP_BNE:  branch_cond = BR_NE;
      OP_BLEZ: branch_cond = BR_LEZ;
      OP_BGTZ: branch_cond = BR_GTZ;
      OP_REGIMM: begin
        case (rt)
          RT_BLTZ:   branch_cond = BR_LTZ;
          RT_BGEZ:   branch_cond = BR_GEZ;
          RT_BLTZAL: begin
            branch_cond = BR_LTZ;
            link        = 1'b1; // Return address to $31
          end
          RT_BGEZAL: begin
            branch_cond = BR_GEZ;
            link        = 1'b1;
          end
          default:   branch_cond = BR_NONE; // Flagged illegal by maindec
        endcase
      end
      default: branch_cond = BR_NONE;
    endcase
  end

endmodule

`default_nettype wire

/* aludec.sv */
`timescale 1ns/1ps
`default_nettype none

module aludec import mips_pkg::*; (
  input  logic [1:0] aluop,
  input  logic [5:0] op,
  input  logic [5:0] funct,
  output logic [3:0] alu_ctrl
);

  always_comb begin
    alu_ctrl = ALU_ADD;
    case (aluop)
      AOP_ADD:  alu_ctrl = ALU_ADD;   // Load/store address
      AOP_PASS: alu_ctrl = ALU_PASSA; // Jump target through A
      AOP_DECODE: begin
        if (op == OP_RTYPE) begin
          case (funct)
            FN_ADDU: alu_ctrl = ALU_ADD;
            FN_SUBU: alu_ctrl = ALU_SUB;
            FN_AND:  alu_ctrl = ALU_AND;
            FN_OR:   alu_ctrl = ALU_OR;
            FN_XOR:  alu_ctrl = ALU_XOR;
            FN_SLT:  alu_ctrl = ALU_SLT;
            FN_SLTU: alu_ctrl = ALU_SLTU;
            FN_SLL:  alu_ctrl = ALU_SLL;
            FN_SRL:  alu_ctrl = ALU_SRL;
            FN_SRA:  alu_ctrl = ALU_SRA;
            FN_MTHI: alu_ctrl = ALU_MTHI; // ALU owns HI
            FN_MTLO: alu_ctrl = ALU_MTLO; // ALU owns LO
            default: alu_ctrl = ALU_ADD;
          endcase
        end else begin
          case (op)
            OP_ADDIU: alu_ctrl = ALU_ADD;
            OP_ANDI:  alu_ctrl = ALU_AND;
            OP_ORI:   alu_ctrl = ALU_OR;
            OP_XORI:  alu_ctrl = ALU_XOR;
            OP_SLTI:  alu_ctrl = ALU_SLT;
            OP_SLTIU: alu_ctrl = ALU_SLTU;
            OP_LUI:   alu_ctrl = ALU_LUI;
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM:
              alu_ctrl = ALU_SUB; // Branch compare
            default:  alu_ctrl = ALU_ADD;
          endcase
        end
      end
      default: alu_ctrl = ALU_ADD; // Unused class
    endcase
  end

endmodule

`default_nettype wire

/* maindec.sv */
`timescale 1ns/1ps
`default_nettype none

module maindec import mips_pkg::*; (
  input  logic [5:0] op,
  input  logic [5:0] funct,
  input  logic [4:0] rt,
  output logic       regwrite,
  output logic       regdst2,   // Dest is $31
  output logic       regdst1,   // Dest is rd
  output logic       alusrc,    // B operand is immediate
  output logic       branch,
  output logic       mem_write,
  output logic       memtoreg,
  output logic       jump1,     // Target from register
  output logic       jump,
  output logic       illegal,
  output logic [1:0] aluop,
  output logic [2:0] load_code
);

  always_comb begin
    regwrite  = 1'b0; // Everything inactive unless decoded
    regdst2   = 1'b0;
    regdst1   = 1'b0;
    alusrc    = 1'b0;
    branch    = 1'b0;
    mem_write = 1'b0;
    memtoreg  = 1'b0;
    jump1     = 1'b0;
    jump      = 1'b0;
    illegal   = 1'b0;
    aluop     = AOP_ADD;
    load_code = LD_NONE;
    case (op)
      OP_RTYPE: begin
        case (funct)
          FN_MTHI, FN_MTLO: aluop = AOP_DECODE; // HI/LO live in the ALU, no reg write
          FN_JR, FN_JALR: begin
            branch   = 1'b1;
            jump1    = 1'b1;
            jump     = 1'b1;
            aluop    = AOP_PASS;
            regwrite = (funct == FN_JALR); // JALR links into $31
            regdst2  = (funct == FN_JALR);
          end
          FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
          FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA: begin
            regwrite = 1'b1;
            regdst1  = 1'b1;
            aluop    = AOP_DECODE;
          end
          default: illegal = 1'b1; // Unlisted function
        endcase
      end
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR: begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
        memtoreg = 1'b1;
        aluop    = AOP_ADD;
        case (op)
          OP_LB:   load_code = LD_B;
          OP_LBU:  load_code = LD_BU;
          OP_LH:   load_code = LD_H;
          OP_LHU:  load_code = LD_HU;
          OP_LWL:  load_code = LD_WL;
          OP_LWR:  load_code = LD_WR;
          default: load_code = LD_W;
        endcase
      end
      OP_SB, OP_SH, OP_SW: begin
        alusrc    = 1'b1;
        mem_write = 1'b1;
        aluop     = AOP_ADD;
      end
      OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
        branch = 1'b1;
        aluop  = AOP_DECODE; // Compare via subtract
      end
      OP_REGIMM: begin
        if (rt == RT_BLTZ || rt == RT_BGEZ || rt == RT_BLTZAL || rt == RT_BGEZAL) begin
          branch   = 1'b1;
          aluop    = AOP_DECODE;
          regwrite = rt[4]; // AL forms write $31
          regdst2  = rt[4];
        end else begin
          illegal = 1'b1; // Unknown rt selector
        end
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
        aluop    = AOP_DECODE;
      end
      OP_J, OP_JAL: begin
        branch   = 1'b1;
        jump     = 1'b1;
        aluop    = AOP_PASS;
        regwrite = (op == OP_JAL);
        regdst2  = (op == OP_JAL);
      end
      default: illegal = 1'b1; // Undefined opcode
    endcase
  end

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE  = 6'b000000;
  localparam logic [5:0] OP_REGIMM = 6'b000001; // rt field picks the branch
  localparam logic [5:0] OP_J      = 6'b000010;
  localparam logic [5:0] OP_JAL    = 6'b000011;
  localparam logic [5:0] OP_BEQ    = 6'b000100;
  localparam logic [5:0] OP_BNE    = 6'b000101;
  localparam logic [5:0] OP_BLEZ   = 6'b000110;
  localparam logic [5:0] OP_BGTZ   = 6'b000111;
  localparam logic [5:0] OP_ADDIU  = 6'b001001;
  localparam logic [5:0] OP_SLTI   = 6'b001010;
  localparam logic [5:0] OP_SLTIU  = 6'b001011;
  localparam logic [5:0] OP_ANDI   = 6'b001100;
  localparam logic [5:0] OP_ORI    = 6'b001101;
  localparam logic [5:0] OP_XORI   = 6'b001110;
  localparam logic [5:0] OP_LUI    = 6'b001111;
  localparam logic [5:0] OP_LB     = 6'b100000;
  localparam logic [5:0] OP_LH     = 6'b100001;
  localparam logic [5:0] OP_LWL    = 6'b100010;
  localparam logic [5:0] OP_LW     = 6'b100011;
  localparam logic [5:0] OP_LBU    = 6'b100100;
  localparam logic [5:0] OP_LHU    = 6'b100101;
  localparam logic [5:0] OP_LWR    = 6'b100110;
  localparam logic [5:0] OP_SB     = 6'b101000;
  localparam logic [5:0] OP_SH     = 6'b101001;
  localparam logic [5:0] OP_SW     = 6'b101011;

  // R-type function field, instr[5:0]
  localparam logic [5:0] FN_SLL  = 6'b000000;
  localparam logic [5:0] FN_SRL  = 6'b000010;
  localparam logic [5:0] FN_SRA  = 6'b000011;
  localparam logic [5:0] FN_JR   = 6'b001000;
  localparam logic [5:0] FN_JALR = 6'b001001;
  localparam logic [5:0] FN_MTHI = 6'b010001;
  localparam logic [5:0] FN_MTLO = 6'b010100; // Core specific encoding
  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUBU = 6'b100011;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_XOR  = 6'b100110;
  localparam logic [5:0] FN_SLT  = 6'b101010;
  localparam logic [5:0] FN_SLTU = 6'b101011;

  // REGIMM selectors in rt, bit 4 means link
  localparam logic [4:0] RT_BLTZ   = 5'b00000;
  localparam logic [4:0] RT_BGEZ   = 5'b00001;
  localparam logic [4:0] RT_BLTZAL = 5'b10000;
  localparam logic [4:0] RT_BGEZAL = 5'b10001;

  // Load format codes
  localparam logic [2:0] LD_B    = 3'd0;
  localparam logic [2:0] LD_BU   = 3'd1;
  localparam logic [2:0] LD_H    = 3'd2;
  localparam logic [2:0] LD_HU   = 3'd3;
  localparam logic [2:0] LD_NONE = 3'd4; // Not a load
  localparam logic [2:0] LD_W    = 3'd5;
  localparam logic [2:0] LD_WL   = 3'd6;
  localparam logic [2:0] LD_WR   = 3'd7;

  // ALU op class from the main decoder
  localparam logic [1:0] AOP_ADD    = 2'b00; // Address calc
  localparam logic [1:0] AOP_PASS   = 2'b01; // Jumps, pass operand A
  localparam logic [1:0] AOP_DECODE = 2'b10; // Look at op and funct

  // ALU operations
  localparam logic [3:0] ALU_ADD   = 4'd0;
  localparam logic [3:0] ALU_SUB   = 4'd1;
  localparam logic [3:0] ALU_AND   = 4'd2;
  localparam logic [3:0] ALU_OR    = 4'd3;
  localparam logic [3:0] ALU_XOR   = 4'd4;
  localparam logic [3:0] ALU_SLT   = 4'd5;
  localparam logic [3:0] ALU_SLTU  = 4'd6;
  localparam logic [3:0] ALU_SLL   = 4'd7;
  localparam logic [3:0] ALU_SRL   = 4'd8;
  localparam logic [3:0] ALU_SRA   = 4'd9;
  localparam logic [3:0] ALU_LUI   = 4'd10;
  localparam logic [3:0] ALU_PASSA = 4'd11;
  localparam logic [3:0] ALU_MTHI  = 4'd12;
  localparam logic [3:0] ALU_MTLO  = 4'd13;

  // Branch conditions for the branch unit
  localparam logic [2:0] BR_NONE = 3'd0;
  localparam logic [2:0] BR_EQ   = 3'd1;
  localparam logic [2:0] BR_NE   = 3'd2;
  localparam logic [2:0] BR_LEZ  = 3'd3;
  localparam logic [2:0] BR_GTZ  = 3'd4;
  localparam logic [2:0] BR_LTZ  = 3'd5;
  localparam logic [2:0] BR_GEZ  = 3'd6;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  op;
      logic [25:0] target;
    } j;
  } instr_t;

endpackage

`default_nettype wire
